//--- test/i2s_dsp_rx_trace.txt
# name stereo lsb_first len(0=8,1=16,2=24,3=32) offset mode(0 plain,1 gaps,2 hold,3 abort) nsend nexp
# then nsend lines of sd0 sd1 words (hex), then nexp lines of expected ch0 ch1 (hex)
mono_msb16 0 0 1 0 0 3 3
a5c3 0
1234 0
ffee 0
a5c3 0
1234 0
ffee 0
stereo_lsb24_off3 1 1 2 3 0 2 2
123456 abcdef
fedcba 0f0f0f
123456 abcdef
fedcba 0f0f0f
stereo_msb8_gaps 1 0 0 5 1 4 4
a1 b2
c3 d4
e5 f6
07 18
a1 b2
c3 d4
e5 f6
07 18
stereo_lsb32_gaps 1 1 3 1 1 3 3
deadbeef 01234567
89abcdef cafef00d
80000001 7ffffffe
deadbeef 01234567
89abcdef cafef00d
80000001 7ffffffe
stereo_overflow16 1 0 1 2 2 2 1
1111 2222
3333 4444
3333 4444
mono_abort16 0 0 1 1 3 2 1
0bad 0
600d 0
600d 0

//--- i2s_dsp_rx.f
source/i2s_dsp_rx_pkg.sv
source/i2s_dsp_rx_cfg.sv
source/i2s_dsp_rx_frame.sv
source/i2s_dsp_rx_deser.sv
source/i2s_dsp_rx_outbuf.sv
source/i2s_dsp_rx.sv
test/tb_i2s_dsp_rx.sv

//--- run.sh
#!/bin/sh
# Build and run the i2s_dsp_rx testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f i2s_dsp_rx.f --top-module tb_i2s_dsp_rx -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- test/tb_i2s_dsp_rx.sv
`timescale 1ns/1ns

module tb_i2s_dsp_rx;

    localparam int          CLK_PERIOD = 20;
    localparam logic [31:0] LFSR_SEED  = 32'hdaf21ff0;
    localparam int          MAX_TESTS  = 8;
    localparam int          MAX_WORDS  = 8;

    logic        sck_i;
    logic        rstn_i;
    logic        sd0_i;
    logic        sd1_i;
    logic        ws_i;
    logic        cfg_en_i;
    logic        cfg_stereo_i;
    logic        cfg_lsb_first_i;
    logic [1:0]  cfg_word_len_i;
    logic [8:0]  cfg_offset_i;
    logic [31:0] data_o;
    logic        valid_o;
    logic        ready_i;
    logic        err_o;

    // Trace contents, one entry per test
    string       t_name   [MAX_TESTS];
    int          t_stereo [MAX_TESTS];
    int          t_lsb    [MAX_TESTS];
    int          t_len    [MAX_TESTS];
    int          t_off    [MAX_TESTS];
    int          t_mode   [MAX_TESTS];
    int          t_nsend  [MAX_TESTS];
    int          t_nexp   [MAX_TESTS];
    logic [31:0] t_sd0    [MAX_TESTS][MAX_WORDS];
    logic [31:0] t_sd1    [MAX_TESTS][MAX_WORDS];
    logic [31:0] t_e0     [MAX_TESTS][MAX_WORDS];
    logic [31:0] t_e1     [MAX_TESTS][MAX_WORDS];

    int          num_tests;
    int          fd;
    longint      limit_ns = 0;
    int          err_cnt;
    int          test_errs;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_q = LFSR_SEED;

    i2s_dsp_rx i_i2s_dsp_rx (
        .sck_i           (sck_i),
        .rstn_i          (rstn_i),
        .sd0_i           (sd0_i),
        .sd1_i           (sd1_i),
        .ws_i            (ws_i),
        .cfg_en_i        (cfg_en_i),
        .cfg_stereo_i    (cfg_stereo_i),
        .cfg_lsb_first_i (cfg_lsb_first_i),
        .cfg_word_len_i  (i2s_dsp_rx_pkg::word_len_e'(cfg_word_len_i)),
        .cfg_offset_i    (cfg_offset_i),
        .data_o          (data_o),
        .valid_o         (valid_o),
        .ready_i         (ready_i),
        .err_o           (err_o)
    );

    initial begin
        sck_i = 1'b0;
        forever #(CLK_PERIOD / 2) sck_i = ~sck_i;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic take_bit();
        take_bit = lfsr_q[0];
        lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    endfunction

    function automatic int word_bits(input int len);
        word_bits = 8 * (len + 1);
    endfunction

    // Overflow pulses seen by the sink
    always @(negedge sck_i) begin
        if (err_o) begin
            err_cnt++;
        end
    end

    // Next non-comment line of the trace
    task automatic next_line(output string line);
        int r;
        line = "";
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r > 1 && line.getc(0) != 8'h23) begin
                return;
            end
        end
        line = "";
    endtask

    task automatic load_trace();
        string line;
        int    n;
        int    w;
        int    bits;
        bits = 0;
        num_tests = 0;
        next_line(line);
        while (line != "" && num_tests < MAX_TESTS) begin
            n = num_tests;
            void'($sscanf(line, "%s %d %d %d %d %d %d %d", t_name[n], t_stereo[n],
                t_lsb[n], t_len[n], t_off[n], t_mode[n], t_nsend[n], t_nexp[n]));
            for (w = 0; w < t_nsend[n]; w++) begin
                next_line(line);
                void'($sscanf(line, "%h %h", t_sd0[n][w], t_sd1[n][w]));
            end
            for (w = 0; w < t_nexp[n]; w++) begin
                next_line(line);
                void'($sscanf(line, "%h %h", t_e0[n][w], t_e1[n][w]));
            end
            bits += t_off[n] + t_nsend[n] * word_bits(t_len[n]);
            num_tests++;
            next_line(line);
        end
        limit_ns = (longint'(bits) * CLK_PERIOD * 3) / 2 + 2000;
    endtask

    // Sync pulse, offset noise, then the words bit by bit
    task automatic send_words(input int t, input int row0, input int nrows,
                              input int max_bits);
        int len;
        int nbits;
        int c;
        int idx;
        int w;
        int pos;
        len = word_bits(t_len[t]);
        nbits = nrows * len;
        if (max_bits < nbits) begin
            nbits = max_bits;
        end
        for (c = 0; c < t_off[t] + nbits; c++) begin
            @(posedge sck_i);
            ws_i <= (c == 0);
            if (c < t_off[t]) begin
                sd0_i <= take_bit();
                sd1_i <= take_bit();
            end else begin
                idx = c - t_off[t];
                w = row0 + idx / len;
                pos = t_lsb[t] != 0 ? idx % len : len - 1 - idx % len;
                sd0_i <= t_sd0[t][w][pos];
                sd1_i <= t_sd1[t][w][pos];
            end
        end
        @(posedge sck_i);
        ws_i  <= 1'b0;
        sd0_i <= 1'b0;
        sd1_i <= 1'b0;
    endtask

    task automatic check_word(input int t, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("ERROR %s: expected %h, actual %h", t_name[t], exp, act);
            test_errs++;
        end
    endtask

    // One word per transfer, sampled half a cycle before its edge
    task automatic take_word(input int t, output logic [31:0] word);
        int gap;
        do begin
            @(negedge sck_i);
        end while (!(valid_o && ready_i));
        word = data_o;
        @(posedge sck_i);
        if (t_mode[t] == 1) begin
            gap = int'(take_bit()) * 2;
            gap += int'(take_bit());
            if (gap > 0) begin
                ready_i <= 1'b0;
                repeat (gap) @(posedge sck_i);
                ready_i <= 1'b1;
            end
        end
    endtask

    task automatic collect(input int t);
        int          w;
        logic [31:0] word;
        for (w = 0; w < t_nexp[t]; w++) begin
            take_word(t, word);
            check_word(t, t_e0[t][w], word);
            if (t_stereo[t] != 0) begin
                take_word(t, word);
                check_word(t, t_e1[t][w], word);
            end
        end
    endtask

    task automatic run_test(input int t);
        int row0;
        int err_base;
        row0 = 0;
        test_errs = 0;
        @(posedge sck_i);
        cfg_en_i        <= 1'b0;
        cfg_stereo_i    <= t_stereo[t][0];
        cfg_lsb_first_i <= t_lsb[t][0];
        cfg_word_len_i  <= t_len[t][1:0];
        cfg_offset_i    <= t_off[t][8:0];
        ready_i         <= (t_mode[t] != 2);
        repeat (3) @(posedge sck_i);
        cfg_en_i <= 1'b1;
        @(posedge sck_i);
        if (t_mode[t] == 1) begin
            // Settings move under a running receiver, which keeps what it captured
            cfg_stereo_i    <= ~t_stereo[t][0];
            cfg_lsb_first_i <= ~t_lsb[t][0];
            cfg_word_len_i  <= ~t_len[t][1:0];
            cfg_offset_i    <= t_off[t][8:0] + 9'd7;
        end
        repeat (2) @(posedge sck_i);
        err_base = err_cnt;
        if (t_mode[t] == 3) begin
            // Abort halfway through the first word
            send_words(t, 0, 1, word_bits(t_len[t]) / 2);
            cfg_en_i <= 1'b0;
            repeat (word_bits(t_len[t]) + 2) begin
                @(negedge sck_i);
                assert (!valid_o) else begin
                    $display("%s: valid_o rose after the receiver was disabled", t_name[t]);
                    test_errs++;
                end
            end
            @(posedge sck_i);
            cfg_en_i <= 1'b1;
            repeat (3) @(posedge sck_i);
            row0 = 1;
        end
        if (t_mode[t] == 2) begin
            send_words(t, 0, t_nsend[t], 1 << 20);
            repeat (2) @(posedge sck_i);
            assert (err_cnt - err_base == 1) else begin
                $display("ERROR %s: expected %0d, actual %0d",
                    t_name[t], 1, err_cnt - err_base);
                test_errs++;
            end
            ready_i <= 1'b1;
            collect(t);
            @(negedge sck_i);
            assert (!valid_o) else begin
                $display("%s: valid_o stayed high after the held pair left", t_name[t]);
                test_errs++;
            end
        end else begin
            fork
                send_words(t, row0, t_nsend[t] - row0, 1 << 20);
                collect(t);
            join
            assert (err_cnt == err_base) else begin
                $display("ERROR %s: expected %0d, actual %0d",
                    t_name[t], 0, err_cnt - err_base);
                test_errs++;
            end
        end
        @(posedge sck_i);
        cfg_en_i <= 1'b0;
        ready_i  <= 1'b1;
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: passed", t_name[t]);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", t_name[t], test_errs);
        end
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("Timeout: the tests did not finish in the expected time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rstn_i          = 1'b0;
        sd0_i           = 1'b0;
        sd1_i           = 1'b0;
        ws_i            = 1'b0;
        cfg_en_i        = 1'b0;
        cfg_stereo_i    = 1'b0;
        cfg_lsb_first_i = 1'b0;
        cfg_word_len_i  = 2'd0;
        cfg_offset_i    = 9'd0;
        ready_i         = 1'b1;
        fd = $fopen("test/i2s_dsp_rx_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file test/i2s_dsp_rx_trace.txt");
            tests_failed = 1;
        end else begin
            load_trace();
            $fclose(fd);
            repeat (10) @(posedge sck_i);
            rstn_i <= 1'b1;
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && num_tests > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- source/i2s_dsp_rx.sv
`timescale 1ns/1ns

module i2s_dsp_rx (
    input  logic                                sck_i,
    input  logic                                rstn_i,

    input  logic                                sd0_i,
    input  logic                                sd1_i,
    input  logic                                ws_i,

    input  logic                                cfg_en_i,
    input  logic                                cfg_stereo_i,
    input  logic                                cfg_lsb_first_i,
    input  i2s_dsp_rx_pkg::word_len_e           cfg_word_len_i,
    input  logic [i2s_dsp_rx_pkg::OFFSET_W-1:0] cfg_offset_i,

    output logic [i2s_dsp_rx_pkg::WORD_W-1:0]   data_o,
    output logic                                valid_o,
    input  logic                                ready_i,
    output logic                                err_o
);

    i2s_dsp_rx_pkg::rx_cfg_t    cfg;
    logic                       run;
    i2s_dsp_rx_pkg::frame_ev_t  ev;
    i2s_dsp_rx_pkg::word_pair_t words;
    logic                       word_done;

    i2s_dsp_rx_cfg i_cfg (
        .sck_i           (sck_i),
        .rstn_i          (rstn_i),
        .cfg_en_i        (cfg_en_i),
        .cfg_stereo_i    (cfg_stereo_i),
        .cfg_lsb_first_i (cfg_lsb_first_i),
        .cfg_word_len_i  (cfg_word_len_i),
        .cfg_offset_i    (cfg_offset_i),
        .cfg_o           (cfg),
        .run_o           (run)
    );

    i2s_dsp_rx_frame i_frame (
        .sck_i  (sck_i),
        .rstn_i (rstn_i),
        .run_i  (run),
        .cfg_i  (cfg),
        .ws_i   (ws_i),
        .ev_o   (ev)
    );

    i2s_dsp_rx_deser i_deser (
        .sck_i       (sck_i),
        .rstn_i      (rstn_i),
        .run_i       (run),
        .cfg_i       (cfg),
        .ev_i        (ev),
        .sd0_i       (sd0_i),
        .sd1_i       (sd1_i),
        .words_o     (words),
        .word_done_o (word_done)
    );

    i2s_dsp_rx_outbuf i_outbuf (
        .sck_i       (sck_i),
        .rstn_i      (rstn_i),
        .run_i       (run),
        .cfg_i       (cfg),
        .words_i     (words),
        .word_done_i (word_done),
        .ready_i     (ready_i),
        .data_o      (data_o),
        .valid_o     (valid_o),
        .err_o       (err_o)
    );

endmodule

//--- source/i2s_dsp_rx_outbuf.sv
`timescale 1ns/1ns

module i2s_dsp_rx_outbuf (
    input  logic                              sck_i,
    input  logic                              rstn_i,

    input  logic                              run_i,
    input  i2s_dsp_rx_pkg::rx_cfg_t           cfg_i,
    input  i2s_dsp_rx_pkg::word_pair_t        words_i,
    input  logic                              word_done_i,
    input  logic                              ready_i,

    output logic [i2s_dsp_rx_pkg::WORD_W-1:0] data_o,
    output logic                              valid_o,
    output logic                              err_o
);

    i2s_dsp_rx_pkg::word_pair_t pair_q;
    logic                       pend0_q;
    logic                       pend1_q;

    // Fresh pair is offered straight away in its done cycle
    always_comb begin
        if (word_done_i) begin
            data_o = words_i.ch0;
        end else if (pend0_q) begin
            data_o = pair_q.ch0;
        end else if (pend1_q) begin
            data_o = pair_q.ch1;
        end else begin
            data_o = '0;
        end
    end

    assign valid_o = word_done_i | pend0_q | pend1_q;

    // New pair lands on top of an undelivered word
    assign err_o = word_done_i & (pend0_q | pend1_q);

    always_ff @(posedge sck_i) begin
        if (word_done_i) begin
            pair_q <= words_i;
        end
    end

    always_ff @(posedge sck_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pend0_q <= 1'b0;
            pend1_q <= 1'b0;
        end else if (!run_i) begin
            pend0_q <= 1'b0;
            pend1_q <= 1'b0;
        end else if (word_done_i) begin
            // ch0 leaves on this edge if the sink is ready
            pend0_q <= ~ready_i;
            pend1_q <= cfg_i.stereo;
        end else if (ready_i) begin
            // ch0 always goes before ch1
            if (pend0_q) begin
                pend0_q <= 1'b0;
            end else if (pend1_q) begin
                pend1_q <= 1'b0;
            end
        end
    end

endmodule

//--- source/i2s_dsp_rx_deser.sv
`timescale 1ns/1ns

module i2s_dsp_rx_deser (
    input  logic                       sck_i,
    input  logic                       rstn_i,

    input  logic                       run_i,
    input  i2s_dsp_rx_pkg::rx_cfg_t    cfg_i,
    input  i2s_dsp_rx_pkg::frame_ev_t  ev_i,
    input  logic                       sd0_i,
    input  logic                       sd1_i,

    output i2s_dsp_rx_pkg::word_pair_t words_o,
    output logic                       word_done_o
);

    logic [i2s_dsp_rx_pkg::WORD_W-1:0] sr0_q;
    logic [i2s_dsp_rx_pkg::WORD_W-1:0] sr1_q;
    logic                              done_q;

    // Next shift register value for one data line
    function automatic logic [i2s_dsp_rx_pkg::WORD_W-1:0] shift_bit(
        input logic [i2s_dsp_rx_pkg::WORD_W-1:0] sr,
        input logic                              sd,
        input logic                              lsb_first,
        input logic                              first
    );
        logic [i2s_dsp_rx_pkg::WORD_W-1:0] base;
        // A new word starts from an empty register
        base = first ? '0 : sr;
        if (lsb_first) begin
            shift_bit = {sd, base[i2s_dsp_rx_pkg::WORD_W-1:1]};
        end else begin
            shift_bit = {base[i2s_dsp_rx_pkg::WORD_W-2:0], sd};
        end
    endfunction

    // MSB-first words already sit at bit 0, LSB-first words sit at the top
    function automatic logic [i2s_dsp_rx_pkg::WORD_W-1:0] align_word(
        input logic [i2s_dsp_rx_pkg::WORD_W-1:0] sr,
        input i2s_dsp_rx_pkg::rx_cfg_t           cfg
    );
        logic [i2s_dsp_rx_pkg::WORD_W-1:0] word;
        word = sr;
        if (cfg.lsb_first) begin
            case (cfg.word_len)
                i2s_dsp_rx_pkg::LEN_8:  word = sr >> 24;
                i2s_dsp_rx_pkg::LEN_16: word = sr >> 16;
                i2s_dsp_rx_pkg::LEN_24: word = sr >> 8;
                default:                word = sr;
            endcase
        end
        align_word = word;
    endfunction

    always_ff @(posedge sck_i, negedge rstn_i) begin
        if (!rstn_i) begin
            sr0_q  <= '0;
            sr1_q  <= '0;
            done_q <= 1'b0;
        end else if (!run_i) begin
            // Drop any partial word
            sr0_q  <= '0;
            sr1_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= ev_i.last_bit;
            if (ev_i.shift) begin
                sr0_q <= shift_bit(sr0_q, sd0_i, cfg_i.lsb_first, ev_i.first_bit);
                if (cfg_i.stereo) begin
                    sr1_q <= shift_bit(sr1_q, sd1_i, cfg_i.lsb_first, ev_i.first_bit);
                end
            end
        end
    end

    // Registers still hold the complete word during the done cycle
    assign words_o.ch0 = align_word(sr0_q, cfg_i);
    assign words_o.ch1 = cfg_i.stereo ? align_word(sr1_q, cfg_i) : '0;
    assign word_done_o = done_q;

endmodule

//--- source/i2s_dsp_rx_frame.sv
`timescale 1ns/1ns

module i2s_dsp_rx_frame (
    input  logic                      sck_i,
    input  logic                      rstn_i,

    input  logic                      run_i,
    input  i2s_dsp_rx_pkg::rx_cfg_t   cfg_i,
    input  logic                      ws_i,

    output i2s_dsp_rx_pkg::frame_ev_t ev_o
);

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_OFFSET,
        ST_RUN
    } state_e;

    state_e                              state_q;
    logic [i2s_dsp_rx_pkg::OFFSET_W-1:0] off_cnt_q;
    logic [i2s_dsp_rx_pkg::CNT_W-1:0]    bit_cnt_q;
    logic [i2s_dsp_rx_pkg::CNT_W-1:0]    last_idx;
    i2s_dsp_rx_pkg::frame_ev_t           ev;

    // Index of the final bit of a word
    always_comb begin
        case (cfg_i.word_len)
            i2s_dsp_rx_pkg::LEN_8:  last_idx = 5'd7;
            i2s_dsp_rx_pkg::LEN_16: last_idx = 5'd15;
            i2s_dsp_rx_pkg::LEN_24: last_idx = 5'd23;
            default:                last_idx = 5'd31;
        endcase
    end

    always_comb begin
        ev = '0;
        case (state_q)
            ST_WAIT: begin
                // Zero offset, so bit 0 rides on the sync edge itself
                if (ws_i && cfg_i.offset == '0) begin
                    ev.first_bit = 1'b1;
                    ev.shift     = 1'b1;
                end
            end
            ST_OFFSET: begin
                if (off_cnt_q == cfg_i.offset) begin
                    ev.first_bit = 1'b1;
                    ev.shift     = 1'b1;
                end
            end
            ST_RUN: begin
                ev.shift     = 1'b1;
                ev.first_bit = (bit_cnt_q == '0);
                ev.last_bit  = (bit_cnt_q == last_idx);
            end
            default: begin
                ev = '0;
            end
        endcase
        if (!run_i) begin
            ev = '0;
        end
    end

    always_ff @(posedge sck_i, negedge rstn_i) begin
        if (!rstn_i) begin
            state_q   <= ST_WAIT;
            off_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else if (!run_i) begin
            state_q   <= ST_WAIT;
            off_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_WAIT: begin
                    if (ws_i) begin
                        if (cfg_i.offset == '0) begin
                            state_q   <= ST_RUN;
                            bit_cnt_q <= 5'd1;
                        end else begin
                            // The sync edge counts as the first offset cycle
                            state_q   <= ST_OFFSET;
                            off_cnt_q <= 9'd1;
                        end
                    end
                end
                ST_OFFSET: begin
                    if (ev.first_bit) begin
                        state_q   <= ST_RUN;
                        bit_cnt_q <= 5'd1;
                    end else begin
                        off_cnt_q <= off_cnt_q + 1'b1;
                    end
                end
                ST_RUN: begin
                    // Words follow back to back, ws is not looked at again
                    bit_cnt_q <= ev.last_bit ? '0 : bit_cnt_q + 1'b1;
                end
                default: begin
                    state_q <= ST_WAIT;
                end
            endcase
        end
    end

    assign ev_o = ev;

endmodule

//--- source/i2s_dsp_rx_cfg.sv
`timescale 1ns/1ns

module i2s_dsp_rx_cfg (
    input  logic                                 sck_i,
    input  logic                                 rstn_i,

    input  logic                                 cfg_en_i,
    input  logic                                 cfg_stereo_i,
    input  logic                                 cfg_lsb_first_i,
    input  i2s_dsp_rx_pkg::word_len_e            cfg_word_len_i,
    input  logic [i2s_dsp_rx_pkg::OFFSET_W-1:0]  cfg_offset_i,

    output i2s_dsp_rx_pkg::rx_cfg_t              cfg_o,
    output logic                                 run_o
);

    i2s_dsp_rx_pkg::rx_cfg_t cfg_q;
    logic                    run_q;

    // Settings follow the inputs only while the receiver is off
    always_ff @(posedge sck_i, negedge rstn_i) begin
        if (!rstn_i) begin
            cfg_q <= '0;
        end else if (!cfg_en_i) begin
            cfg_q.stereo    <= cfg_stereo_i;
            cfg_q.lsb_first <= cfg_lsb_first_i;
            cfg_q.word_len  <= cfg_word_len_i;
            cfg_q.offset    <= cfg_offset_i;
            cfg_q.spare     <= 1'b0;
        end
    end

    // Registered enable, so the first run cycle already sees the frozen settings
    always_ff @(posedge sck_i, negedge rstn_i) begin
        if (!rstn_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= cfg_en_i;
        end
    end

    assign cfg_o = cfg_q;
    assign run_o = run_q;

endmodule

//--- source/i2s_dsp_rx_pkg.sv
package i2s_dsp_rx_pkg;

    // Output word and shift register width
    localparam int WORD_W = 32;

    // Bit counter covers the longest word
    localparam int CNT_W = 5;

    // Sync-to-data offset in bit clocks
    localparam int OFFSET_W = 9;

    // Supported word lengths
    typedef enum logic [1:0] {
        LEN_8  = 2'd0,
        LEN_16 = 2'd1,
        LEN_24 = 2'd2,
        LEN_32 = 2'd3
    } word_len_e;

    // Frozen receiver configuration
    typedef struct packed {
        logic                stereo;
        logic                lsb_first;
        word_len_e           word_len;
        logic [OFFSET_W-1:0] offset;
        logic                spare;
    } rx_cfg_t;

    // Sampling events of the current bit clock cycle
    typedef struct packed {
        // Bit 0 of a word is on the line
        logic first_bit;
        // Any data bit is on the line
        logic shift;
        // Bit L-1 of a word is on the line
        logic last_bit;
    } frame_ev_t;

    // One word per data line
    typedef struct packed {
        logic [WORD_W-1:0] ch0;
        logic [WORD_W-1:0] ch1;
    } word_pair_t;

endpackage
